// File: include/board_config.svh
`ifndef board_config_svh
`define board_config_svh

// Frequency of the board oscillator in MHz.
`define board_clk_mhz 100

// Rate at which the shown level is latched, slow enough to read by eye.
`define board_slow_clk_hz 1

`endif

// File: verilog/lab_pkg.sv
`default_nettype none

package lab_pkg;

    localparam int mic_bits      = 24;  // INMP441 data word width.
    localparam int i2s_frame_sck = 64;  // Left and right halves together.
    localparam int i2s_half_sck  = 32;  // One channel slot.

    // Raw two's complement sample as it comes off the wire.
    typedef logic signed [mic_bits-1:0] mic_sample_t;

    // Magnitude never exceeds the largest positive sample.
    typedef logic [mic_bits-1:0] mic_mag_t;

    typedef enum logic [1:0] {
        rx_wait_frame,  // Only used until the first ws fall after reset.
        rx_skip,        // The I2S delay slot before the MSB.
        rx_shift,       // Capturing the 24 data bits.
        rx_idle_half    // Rest of the left slot and the whole right slot.
    } rx_state_t;

    typedef enum logic {
        mode_live,  // Most recent sample.
        mode_peak   // Largest magnitude since the last clear.
    } meter_mode_t;

endpackage

`default_nettype wire

// File: verilog/i2s_if.sv
`default_nettype none

interface i2s_if;

    logic sck;  // Bit clock made by the receiver.
    logic ws;   // Low selects the left slot.
    logic lr;   // Channel select strap on the microphone.
    logic sd;   // Serial data from the microphone.

    modport receiver (
        output sck, ws, lr,
        input  sd
    );

    modport mic (
        input  sck, ws, lr,
        output sd
    );

endinterface

`default_nettype wire

// File: verilog/slow_clk_gen.sv
`default_nettype none

module slow_clk_gen #(
    parameter int fast_clk_mhz = 100,
    parameter int slow_clk_hz  = 1
) (
    input  logic clk,
    input  logic arst_n,
    output logic slow_clk
);

    localparam int half_period = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int cnt_w       = $clog2(half_period + 1);

    logic [cnt_w-1:0] cnt;
    logic             cnt_end;

    assign cnt_end = cnt == cnt_w'(half_period - 1);  // Last cycle of a half period.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (cnt_end) begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/inmp441_mic_i2s_receiver.sv
`default_nettype none

module inmp441_mic_i2s_receiver #(
    parameter int clk_mhz = 100
) (
    input  logic                 clk,
    input  logic                 arst_n,
    i2s_if.receiver              i2s,
    output lab_pkg::mic_sample_t value,
    output logic                 value_valid
);

    // Keeps sck near 3 MHz, well inside the INMP441 range.
    localparam int sck_half = (clk_mhz / 6 > 1) ? clk_mhz / 6 : 1;
    localparam int presc_w  = $clog2(sck_half) + 1;
    localparam int cnt_w    = $clog2(lab_pkg::i2s_frame_sck);
    localparam int idx_w    = $clog2(lab_pkg::mic_bits);

    logic [presc_w-1:0]   presc;
    logic                 presc_end;
    logic                 sck_rise;
    logic                 sck_fall;
    logic [cnt_w-1:0]     bit_cnt;
    logic [cnt_w-1:0]     bit_cnt_next;
    logic                 frame_start;
    logic [idx_w-1:0]     shift_cnt;
    lab_pkg::mic_sample_t shift_reg;
    logic                 shift_done;
    lab_pkg::rx_state_t   state;

    assign presc_end    = presc == presc_w'(sck_half - 1);
    assign sck_rise     = presc_end & ~i2s.sck;  // sck goes high on this clk edge.
    assign sck_fall     = presc_end & i2s.sck;
    assign bit_cnt_next = bit_cnt + 1'b1;
    assign frame_start  = sck_fall & (bit_cnt == cnt_w'(lab_pkg::i2s_frame_sck - 1));

    assign i2s.lr = 1'b0;  // The microphone answers in the left slot.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc   <= '0;
            i2s.sck <= 1'b0;
        end else if (presc_end) begin
            presc   <= '0;
            i2s.sck <= ~i2s.sck;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Starting at the last count puts reset inside a right slot.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '1;
            i2s.ws  <= 1'b1;
        end else if (sck_fall) begin
            bit_cnt <= bit_cnt_next;
            i2s.ws  <= bit_cnt_next >= cnt_w'(lab_pkg::i2s_half_sck);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= lab_pkg::rx_wait_frame;
            shift_cnt  <= '0;
            shift_done <= 1'b0;
        end else begin
            shift_done <= 1'b0;
            case (state)
                lab_pkg::rx_wait_frame,
                lab_pkg::rx_idle_half: begin
                    if (frame_start) state <= lab_pkg::rx_skip;
                end
                lab_pkg::rx_skip: begin
                    if (sck_rise) begin
                        state     <= lab_pkg::rx_shift;
                        shift_cnt <= '0;
                    end
                end
                lab_pkg::rx_shift: begin
                    if (sck_rise) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (shift_cnt == idx_w'(lab_pkg::mic_bits - 1)) begin
                            state      <= lab_pkg::rx_idle_half;
                            shift_done <= 1'b1;  // Bit 0 is being sampled now.
                        end
                    end
                end
                default: state <= lab_pkg::rx_wait_frame;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lab_pkg::rx_shift && sck_rise) begin
            shift_reg <= {shift_reg[lab_pkg::mic_bits-2:0], i2s.sd};  // MSB first.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) value_valid <= 1'b0;
        else         value_valid <= shift_done;
    end

    always_ff @(posedge clk) begin
        if (shift_done) value <= shift_reg;  // Held until the next frame.
    end

endmodule

`default_nettype wire

// File: verilog/seven_segment_display.sv
`default_nettype none

module seven_segment_display #(
    parameter int refresh_div = 100_000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] number,
    output logic [7:0]  abcdefgh,
    output logic [7:0]  digit
);

    localparam int cnt_w = $clog2(refresh_div + 1);

    logic [cnt_w-1:0] refresh_cnt;
    logic             step;
    logic [2:0]       idx;
    logic [3:0]       nibble;

    // Segment order is a..g then the decimal point, which stays dark.
    function automatic logic [7:0] hex_segments(input logic [3:0] n);
        logic [7:0] seg;
        case (n)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;  // Lower case b.
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;  // Lower case d.
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
        return seg;
    endfunction

    assign step   = refresh_cnt == cnt_w'(refresh_div - 1);
    assign nibble = number[idx*4 +: 4];  // Digit 0 is the rightmost one.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            refresh_cnt <= '0;
            idx         <= '0;
            digit       <= '0;
            abcdefgh    <= '0;
        end else if (step) begin
            refresh_cnt <= '0;
            idx         <= idx + 1'b1;  // Wraps from 7 back to 0.
            digit       <= 8'b1 << idx;
            abcdefgh    <= hex_segments(nibble);
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lab_top.sv
`default_nettype none

module lab_top #(
    parameter int refresh_div = 100_000
) (
    input  logic                 clk,
    input  logic                 slow_clk,
    input  logic                 arst_n,
    input  logic [4:0]           key,
    input  logic [15:0]          sw,
    input  lab_pkg::mic_sample_t mic,
    input  logic                 mic_valid,
    output logic [15:0]          led,
    output logic [7:0]           abcdefgh,
    output logic [7:0]           digit
);

    localparam lab_pkg::mic_sample_t mic_min = {1'b1, {(lab_pkg::mic_bits - 1){1'b0}}};
    localparam lab_pkg::mic_mag_t    mag_sat = {1'b0, {(lab_pkg::mic_bits - 1){1'b1}}};

    logic [1:0]           clear_sync;
    logic [1:0]           mode_sync;
    logic [1:0]           slow_q;
    logic                 clear;
    logic                 slow_rise;
    lab_pkg::meter_mode_t mode;
    lab_pkg::mic_mag_t    mag_now;
    lab_pkg::mic_mag_t    live_mag;
    lab_pkg::mic_mag_t    peak_mag;
    lab_pkg::mic_mag_t    sel_mag;
    lab_pkg::mic_mag_t    shown_mag;
    logic [7:0]           count;
    logic [7:0]           shown_count;
    logic [15:0]          bar;

    // Button and switch come straight from the board pins.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clear_sync <= '0;
            mode_sync  <= '0;
            slow_q     <= '0;
        end else begin
            clear_sync <= {clear_sync[0], key[0]};
            mode_sync  <= {mode_sync[0], sw[0]};
            slow_q     <= {slow_q[0], slow_clk};
        end
    end

    assign clear     = clear_sync[1];
    assign mode      = mode_sync[1] ? lab_pkg::mode_peak : lab_pkg::mode_live;
    assign slow_rise = slow_q[0] & ~slow_q[1];

    // The most negative sample has no positive twin, so it saturates.
    always_comb begin
        if (!mic[lab_pkg::mic_bits-1]) mag_now = lab_pkg::mic_mag_t'(mic);
        else if (mic == mic_min)       mag_now = mag_sat;
        else                           mag_now = lab_pkg::mic_mag_t'(-mic);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live_mag <= '0;
            peak_mag <= '0;
            count    <= '0;
        end else if (clear) begin
            live_mag <= '0;
            peak_mag <= '0;
            count    <= '0;
        end else if (mic_valid) begin
            live_mag <= mag_now;
            if (mag_now > peak_mag) peak_mag <= mag_now;
            count <= count + 1'b1;  // Wraps after 256 samples.
        end
    end

    assign sel_mag = (mode == lab_pkg::mode_peak) ? peak_mag : live_mag;

    // One LED per octave starting at 256.
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            bar[i] = (sel_mag >> (i + 8)) != '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shown_mag   <= '0;
            shown_count <= '0;
            led         <= '0;
        end else if (clear) begin
            shown_mag   <= '0;
            shown_count <= '0;
            led         <= '0;
        end else if (slow_rise) begin
            shown_mag   <= sel_mag;
            shown_count <= count;
            led         <= bar;
        end
    end

    seven_segment_display #(
        .refresh_div (refresh_div)
    ) display0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .number   ({shown_count, shown_mag}),  // Count on digits 7..6.
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire

// File: verilog/board_specific_top.sv
`default_nettype none

`include "board_config.svh"

module board_specific_top #(
    parameter int clk_mhz     = `board_clk_mhz,
    parameter int slow_clk_hz = `board_slow_clk_hz,
    parameter int refresh_div = 100_000  // About 1 ms per digit at 100 MHz.
) (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        btnc,
    input  logic        btnu,
    input  logic        btnl,
    input  logic        btnr,
    input  logic        btnd,

    input  logic [15:0] sw,
    output logic [15:0] led,

    output logic        ca,
    output logic        cb,
    output logic        cc,
    output logic        cd,
    output logic        ce,
    output logic        cf,
    output logic        cg,
    output logic        dp,
    output logic [7:0]  an,

    output logic        mic_sck,
    output logic        mic_ws,
    output logic        mic_lr,
    input  logic        mic_sd
);

    logic                 slow_clk;
    lab_pkg::mic_sample_t mic;
    logic                 mic_valid;
    logic [7:0]           abcdefgh;
    logic [7:0]           digit;

    i2s_if i2s0 ();

    assign mic_sck = i2s0.sck;
    assign mic_ws  = i2s0.ws;
    assign mic_lr  = i2s0.lr;
    assign i2s0.sd = mic_sd;

    // Segments and anodes are active low on this board.
    assign {ca, cb, cc, cd, ce, cf, cg, dp} = ~abcdefgh;
    assign an = ~digit;

    slow_clk_gen #(
        .fast_clk_mhz (clk_mhz),
        .slow_clk_hz  (slow_clk_hz)
    ) slow_clk_gen0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .slow_clk (slow_clk)
    );

    inmp441_mic_i2s_receiver #(
        .clk_mhz (clk_mhz)
    ) mic_rx0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .i2s         (i2s0.receiver),
        .value       (mic),
        .value_valid (mic_valid)
    );

    lab_top #(
        .refresh_div (refresh_div)
    ) lab_top0 (
        .clk       (clk),
        .slow_clk  (slow_clk),
        .arst_n    (arst_n),
        .key       ({btnd, btnu, btnl, btnc, btnr}),  // Right button is key 0.
        .sw        (sw),
        .mic       (mic),
        .mic_valid (mic_valid),
        .led       (led),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

endmodule

`default_nettype wire

// File: dv/i2s_mic_model.sv
`default_nettype none

module i2s_mic_model (
    input  wire                  sck,
    input  wire                  ws,
    input  wire                  lr,
    output logic                 sd,
    output logic                 frame_done,  // Short pulse once bit 0 is on the wire.
    output lab_pkg::mic_sample_t sent_word
);

    lab_pkg::mic_sample_t word_q[$];
    int                   pos;
    logic                 ws_q;
    logic                 ws_fell;
    logic                 active;

    initial begin
        sd         = 1'b0;
        frame_done = 1'b0;
        sent_word  = '0;
        ws_q       = 1'b1;
        pos        = 0;
        active     = 1'b0;
    end

    task automatic push_word(input lab_pkg::mic_sample_t w);
        word_q.push_back(w);
    endtask

    function automatic int queued();
        return word_q.size();
    endfunction

    // Data changes just after the falling sck edge. An empty queue repeats the last word.
    always @(negedge sck) begin
        #1;
        ws_fell = ws_q & ~ws;
        ws_q    = ws;
        if (ws_fell && !lr) begin
            if (word_q.size() > 0) sent_word = word_q.pop_front();
            active = 1'b1;
            pos    = 0;
            sd     = 1'b0;  // The one sck delay slot.
        end else if (active) begin
            pos = pos + 1;
            sd  = (pos <= lab_pkg::mic_bits) ? sent_word[lab_pkg::mic_bits - pos] : 1'b0;
            if (pos == lab_pkg::mic_bits) begin
                frame_done = 1'b1;
                #1 frame_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_board_top.sv
`default_nettype none

`include "board_config.svh"

module tb_board_top;

    localparam int clk_period   = 40;
    localparam int max_cmds     = 64;
    localparam int frame_cycles = 2 * lab_pkg::i2s_frame_sck;  // sck_half is 1 here.

    logic        clk;
    logic        arst_n;
    logic        btnc, btnu, btnl, btnr, btnd;
    logic [15:0] sw;
    logic [15:0] led;
    logic        ca, cb, cc, cd, ce, cf, cg, dp;
    logic [7:0]  an;
    logic        mic_sck, mic_ws, mic_lr, mic_sd;
    logic        frame_done;

    lab_pkg::mic_sample_t sent_word;

    int          op_list[max_cmds];   // 0 sample, 1 rand, 2 clear, 3 mode, 4 expect.
    logic [31:0] arg_list[max_cmds];
    int          n_cmds;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          last_frame;
    integer      seed;

    lab_pkg::mic_mag_t    ref_live;
    lab_pkg::mic_mag_t    ref_peak;
    logic [7:0]           ref_count;
    lab_pkg::meter_mode_t ref_mode;

    board_specific_top #(
        .clk_mhz     (1),
        .slow_clk_hz (31250),
        .refresh_div (4)
    ) dut0 (
        .clk (clk), .arst_n (arst_n),
        .btnc (btnc), .btnu (btnu), .btnl (btnl), .btnr (btnr), .btnd (btnd),
        .sw (sw), .led (led),
        .ca (ca), .cb (cb), .cc (cc), .cd (cd), .ce (ce), .cf (cf), .cg (cg), .dp (dp),
        .an (an),
        .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_lr (mic_lr), .mic_sd (mic_sd)
    );

    i2s_mic_model mic0 (
        .sck (mic_sck), .ws (mic_ws), .lr (mic_lr), .sd (mic_sd),
        .frame_done (frame_done), .sent_word (sent_word)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout: the run took more than %0d clock cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic lab_pkg::mic_mag_t magnitude(input lab_pkg::mic_sample_t s);
        if (!s[23]) return s;
        if (s == 24'h800000) return 24'h7fffff;  // No positive twin.
        return ~s + 1'b1;
    endfunction

    // Every frame the microphone finishes becomes one sample at the meter.
    always @(posedge frame_done) begin
        ref_live   = magnitude(sent_word);
        ref_count  = ref_count + 1'b1;
        last_frame = cycles;
        if (ref_live > ref_peak) ref_peak = ref_live;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Returns {valid, nibble} for an abcdefg pattern.
    function automatic logic [4:0] seg_to_hex(input logic [6:0] s);
        case (s)
            7'b1111110: return 5'h10;
            7'b0110000: return 5'h11;
            7'b1101101: return 5'h12;
            7'b1111001: return 5'h13;
            7'b0110011: return 5'h14;
            7'b1011011: return 5'h15;
            7'b1011111: return 5'h16;
            7'b1110000: return 5'h17;
            7'b1111111: return 5'h18;
            7'b1111011: return 5'h19;
            7'b1110111: return 5'h1a;
            7'b0011111: return 5'h1b;
            7'b1001110: return 5'h1c;
            7'b0111101: return 5'h1d;
            7'b1001111: return 5'h1e;
            7'b1000111: return 5'h1f;
            default:    return 5'h00;
        endcase
    endfunction

    task automatic read_display(output logic [31:0] num);
        logic [7:0] seen;
        logic [4:0] hex;
        int         idx;
        seen = '0;
        num  = '0;
        for (int n = 0; n < 40 && seen != 8'hff; n++) begin
            @(negedge clk);
            idx = -1;
            for (int i = 0; i < 8; i++) begin
                if (an == ~(8'b1 << i)) idx = i;
            end
            if (idx >= 0) begin
                hex = seg_to_hex(~{ca, cb, cc, cd, ce, cf, cg});
                if (!hex[4] || !dp) begin
                    errors = errors + 1;
                    $display("Digit %0d shows a pattern that is not a hex digit", idx);
                end
                num[idx*4 +: 4] = hex[3:0];
                seen[idx]       = 1'b1;
            end
        end
        if (seen != 8'hff) begin
            errors = errors + 1;
            $display("The display did not scan all eight digits");
        end
    endtask

    task automatic expect_state();
        logic [31:0]       num;
        logic [15:0]       exp_led;
        lab_pkg::mic_mag_t shown;
        // A frame that lands during the wait or the scan changes the shown value.
        if (cycles - last_frame > frame_cycles / 4) @(posedge frame_done);
        repeat (64) @(posedge clk);  // Two slow periods.
        shown = (ref_mode == lab_pkg::mode_peak) ? ref_peak : ref_live;
        for (int i = 0; i < 16; i++) begin
            exp_led[i] = shown >= (32'd1 << (i + 8));
        end
        read_display(num);
        compare("display", num, {ref_count, shown});
        compare("led", {16'h0, led}, {16'h0, exp_led});
    endtask

    task automatic send_sample(input lab_pkg::mic_sample_t w);
        @(posedge clk);
        #2 mic0.push_word(w);
        while (mic0.queued() != 0) @(posedge clk);
        @(posedge frame_done);
    endtask

    // Pressed just after a frame so that no sample lands during the press.
    task automatic press_clear();
        @(posedge frame_done);
        repeat (10) @(posedge clk);
        #2 btnr = 1'b1;
        repeat (4) @(posedge clk);
        #2 btnr = 1'b0;
        ref_live  = '0;
        ref_peak  = '0;
        ref_count = '0;
        repeat (6) @(posedge clk);
    endtask

    task automatic load_cases();
        logic [8*128-1:0] line;
        logic [8*16-1:0]  cmd;
        logic [8*16-1:0]  word;
        logic [31:0]      val;
        integer           fd;
        n_cmds = 0;
        fd = $fopen("dv/mic_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/mic_cases.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            while (!$feof(fd) && n_cmds < max_cmds) begin
                line = '0;
                cmd  = '0;
                if ($fgets(line, fd) > 0 && $sscanf(line, "%s", cmd) == 1 && cmd != "#") begin
                    val = '0;
                    if (cmd == "sample") begin
                        void'($sscanf(line, "%s %h", cmd, val));
                        op_list[n_cmds] = 0;
                    end else if (cmd == "rand") begin
                        void'($sscanf(line, "%s %d", cmd, val));
                        op_list[n_cmds] = 1;
                    end else if (cmd == "clear") begin
                        op_list[n_cmds] = 2;
                    end else if (cmd == "mode") begin
                        void'($sscanf(line, "%s %s", cmd, word));
                        val = (word == "peak");
                        op_list[n_cmds] = 3;
                    end else begin
                        op_list[n_cmds] = 4;
                    end
                    arg_list[n_cmds] = val;
                    n_cmds = n_cmds + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        logic [31:0] num;
        logic [31:0] rnd;
        int          n_samples;
        int          n_expects;
        arst_n = 1'b0;
        {btnc, btnu, btnl, btnr, btnd} = '0;
        sw         = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        limit      = 0;
        last_frame = 0;
        seed       = 59;
        ref_live   = '0;
        ref_peak   = '0;
        ref_count  = '0;
        ref_mode   = lab_pkg::mode_live;
        $display("Board default clock is %0d MHz", `board_clk_mhz);
        load_cases();
        n_samples = 0;
        n_expects = 1;
        for (int i = 0; i < n_cmds; i++) begin
            if (op_list[i] == 0) n_samples = n_samples + 1;
            if (op_list[i] == 1) n_samples = n_samples + arg_list[i];
            if (op_list[i] == 4) n_expects = n_expects + 1;
        end
        limit = n_samples * 64 * 4 + n_expects * 256 + n_cmds * 300 + 2000;

        repeat (10) @(posedge clk);
        #2 arst_n = 1'b1;
        // The first sample cannot arrive before the scan is over.
        read_display(num);
        compare("display after reset", num, 32'h0);
        compare("led after reset", {16'h0, led}, 32'h0);

        for (int i = 0; i < n_cmds; i++) begin
            case (op_list[i])
                0: send_sample(arg_list[i][23:0]);
                1: begin
                    for (int k = 0; k < arg_list[i]; k++) begin
                        rnd = $random(seed);
                        send_sample(rnd[23:0]);
                    end
                end
                2: press_clear();
                3: begin
                    @(posedge clk);
                    #2 sw[0] = arg_list[i][0];
                    ref_mode = arg_list[i][0] ? lab_pkg::mode_peak : lab_pkg::mode_live;
                end
                default: expect_state();
            endcase
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
verilog/lab_pkg.sv
verilog/i2s_if.sv
verilog/slow_clk_gen.sv
verilog/inmp441_mic_i2s_receiver.sv
verilog/seven_segment_display.sv
verilog/lab_top.sv
verilog/board_specific_top.sv
dv/i2s_mic_model.sv
dv/tb_board_top.sv

// File: dv/mic_cases.txt
# command [argument]: sample <24-bit hex>, rand <count>, clear, mode live|peak, expect
# expect compares display and LEDs with the testbench reference model
mode live
sample 012345
expect
sample FFFF00
expect
sample 800000
expect
sample 800001
expect
sample 0000FF
expect
sample 008000
expect
sample 007FFF
expect
clear
mode peak
sample 001000
sample FF0000
sample 000200
expect
clear
expect
mode live
rand 260
expect
mode peak
expect
